/* osd_pkg.sv */
`default_nettype none

package osd_pkg;

  // window geometry
  localparam int osd_num_regions = 3;     // character windows
  localparam int osd_win_w = 64;          // window width in pixels
  localparam int osd_win_h = 16;          // window height in lines
  localparam int osd_glyph_bytes = 128;   // 8 px per byte, bit 0 leftmost

  // plain vector types
  typedef logic [11:0] coord_t;           // pixel coordinate
  typedef logic [23:0] rgb_t;             // pixel colour
  typedef logic [6:0]  glyph_addr_t;      // byte address in one glyph memory
  typedef logic [7:0]  glyph_byte_t;      // one row slice of 8 pixels
  typedef logic [11:0] apb_addr_t;
  typedef logic [31:0] apb_data_t;

  localparam rgb_t osd_default_color = 24'h0066cc;  // font colour after reset

  // register map
  localparam apb_addr_t reg_color_addr = 12'h000;   // colour in bits 23:0
  localparam apb_addr_t reg_region_base = 12'h010;  // one word per region
  localparam apb_addr_t glyph_base = 12'h400;       // 0x80 bytes per region

  // the video as it crosses the pins
  typedef struct packed {
    logic hs;
    logic vs;
    logic de;
    rgb_t data;
  } video_t;

  // video tagged with its position in the active picture
  typedef struct packed {
    video_t video;
    coord_t x;
    coord_t y;
  } video_xy_t;

  typedef struct packed {
    logic   en;
    coord_t org_x;                        // left column of the window
    coord_t org_y;                        // top line of the window
  } region_cfg_t;

  // one-cycle write into a region's glyph memory
  typedef struct packed {
    logic        we;
    logic [1:0]  region;                  // target region index
    glyph_addr_t addr;
    glyph_byte_t data;
  } glyph_wr_t;

endpackage

`default_nettype wire

/* timing_gen_xy.sv */
`timescale 1ns/1ps
`default_nettype none

module timing_gen_xy (
  input  logic               pclk,
  input  logic               i_arst_n,
  input  osd_pkg::video_t    i_video,
  output osd_pkg::video_xy_t o_video_xy
);

  logic de_q;                             // de of the pixel held in the register
  logic line_end;                         // falling edge of de
  logic x_run;                            // still inside the same active run

  assign de_q     = o_video_xy.video.de;
  assign line_end = de_q && !i_video.de;
  assign x_run    = de_q && i_video.de;

  // x counts pixels inside the active run, zero on the first de pixel.
  // y counts finished active lines and is held at zero during vs.
  always_ff @(posedge pclk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      o_video_xy <= '0;
    end else begin
      o_video_xy.video <= i_video;

      if (x_run) begin
        o_video_xy.x <= o_video_xy.x + osd_pkg::coord_t'(1);
      end else begin
        o_video_xy.x <= '0;               // restart for the next line
      end

      if (i_video.vs) begin
        o_video_xy.y <= '0;               // new frame
      end else if (line_end) begin
        o_video_xy.y <= o_video_xy.y + osd_pkg::coord_t'(1);
      end
    end
  end

endmodule

`default_nettype wire

/* osd_apb_regs.sv */
`timescale 1ns/1ps
`default_nettype none

module osd_apb_regs (
  input  logic                                                pclk,
  input  logic                                                i_arst_n,
  input  logic                                                i_psel,
  input  logic                                                i_penable,
  input  logic                                                i_pwrite,
  input  osd_pkg::apb_addr_t                                  i_paddr,
  input  osd_pkg::apb_data_t                                  i_pwdata,
  output osd_pkg::apb_data_t                                  o_prdata,
  output logic                                                o_pready,
  output logic                                                o_pslverr,
  output osd_pkg::rgb_t                                       o_color,
  output osd_pkg::region_cfg_t [osd_pkg::osd_num_regions-1:0] o_region_cfg,
  output osd_pkg::glyph_wr_t                                  o_glyph_wr
);

  logic               access;             // APB access phase
  logic               wr_en;
  logic               sel_color;
  logic               sel_region;
  logic               sel_glyph;
  osd_pkg::apb_addr_t region_off;         // offset from the first region word
  osd_pkg::apb_addr_t glyph_off;          // offset into glyph space
  logic [1:0]         region_idx;

  assign access     = i_psel && i_penable;
  assign wr_en      = access && i_pwrite;
  assign region_off = i_paddr - osd_pkg::reg_region_base;
  assign glyph_off  = i_paddr - osd_pkg::glyph_base;
  assign region_idx = region_off[3:2];    // 4 bytes per region word

  // address decode
  assign sel_color  = (i_paddr == osd_pkg::reg_color_addr);
  assign sel_region = (i_paddr >= osd_pkg::reg_region_base) &&
                      (region_off < osd_pkg::apb_addr_t'(4 * osd_pkg::osd_num_regions)) &&
                      (region_off[1:0] == 2'b00);
  assign sel_glyph  = (i_paddr >= osd_pkg::glyph_base) &&
                      (glyph_off <
                       osd_pkg::apb_addr_t'(osd_pkg::osd_num_regions * osd_pkg::osd_glyph_bytes));

  assign o_pready  = 1'b1;                // zero wait states
  assign o_pslverr = access && !(sel_color || sel_region || sel_glyph);

  // read mux, glyph space reads as zero
  always_comb begin
    o_prdata = '0;
    if (access && !i_pwrite) begin
      if (sel_color) begin
        o_prdata = {8'h00, o_color};
      end else if (sel_region) begin
        o_prdata = {o_region_cfg[region_idx].en, 7'h00,
                    o_region_cfg[region_idx].org_y, o_region_cfg[region_idx].org_x};
      end
    end
  end

  always_ff @(posedge pclk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      o_color      <= osd_pkg::osd_default_color;
      o_region_cfg <= '0;                 // all windows off
    end else if (wr_en) begin
      if (sel_color) begin
        o_color <= i_pwdata[23:0];
      end
      if (sel_region) begin
        o_region_cfg[region_idx].en    <= i_pwdata[31];
        o_region_cfg[region_idx].org_y <= i_pwdata[23:12];
        o_region_cfg[region_idx].org_x <= i_pwdata[11:0];
      end
    end
  end

  // glyph byte goes out as a single-cycle strobe
  always_ff @(posedge pclk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      o_glyph_wr <= '0;
    end else begin
      o_glyph_wr.we     <= wr_en && sel_glyph;
      o_glyph_wr.region <= glyph_off[8:7];  // 0x80 bytes per region
      o_glyph_wr.addr   <= glyph_off[6:0];
      o_glyph_wr.data   <= i_pwdata[7:0];
    end
  end

endmodule

`default_nettype wire

/* osd_region.sv */
`timescale 1ns/1ps
`default_nettype none

module osd_region (
  input  logic                 pclk,
  input  logic                 i_arst_n,
  input  osd_pkg::video_xy_t   i_video_xy,
  input  osd_pkg::region_cfg_t i_cfg,
  input  osd_pkg::glyph_wr_t   i_glyph_wr,
  input  logic [1:0]           i_region_id,
  output logic                 o_hit
);

  osd_pkg::glyph_byte_t glyph_mem [osd_pkg::osd_glyph_bytes];

  osd_pkg::coord_t      dx;               // column offset inside the window
  osd_pkg::coord_t      dy;               // row offset inside the window
  logic                 in_x;
  logic                 in_y;
  logic                 in_win;

  logic                 s1_in;
  osd_pkg::glyph_addr_t s1_addr;
  logic [2:0]           s1_bit;

  logic                 s2_in;
  osd_pkg::glyph_byte_t s2_byte;
  logic [2:0]           s2_bit;

  assign dx = i_video_xy.x - i_cfg.org_x;
  assign dy = i_video_xy.y - i_cfg.org_y;

  // offsets only count once the pixel is past the origin
  assign in_x = (i_video_xy.x >= i_cfg.org_x) &&
                (dx < osd_pkg::coord_t'(osd_pkg::osd_win_w));
  assign in_y = (i_video_xy.y >= i_cfg.org_y) &&
                (dy < osd_pkg::coord_t'(osd_pkg::osd_win_h));
  assign in_win = i_cfg.en && i_video_xy.video.de && in_x && in_y;

  // stage 1, window test
  always_ff @(posedge pclk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      s1_in <= 1'b0;
      s2_in <= 1'b0;
    end else begin
      s1_in <= in_win;
      s2_in <= s1_in;
    end
  end

  // byte address is row * 8 + column / 8, 8 bytes per 64-pixel row
  always_ff @(posedge pclk) begin
    s1_addr <= {dy[3:0], dx[5:3]};
    s1_bit  <= dx[2:0];
  end

  // glyph memory, written from the APB side
  always_ff @(posedge pclk) begin
    if (i_glyph_wr.we && (i_glyph_wr.region == i_region_id)) begin
      glyph_mem[i_glyph_wr.addr] <= i_glyph_wr.data;
    end
  end

  // stage 2, synchronous read
  always_ff @(posedge pclk) begin
    s2_byte <= glyph_mem[s1_addr];
    s2_bit  <= s1_bit;
  end

  assign o_hit = s2_in && s2_byte[s2_bit];  // bit 0 is the leftmost pixel

endmodule

`default_nettype wire

/* osd_mixer.sv */
`timescale 1ns/1ps
`default_nettype none

module osd_mixer (
  input  logic                                pclk,
  input  logic                                i_arst_n,
  input  osd_pkg::video_t                     i_video,
  input  logic [osd_pkg::osd_num_regions-1:0] i_hits,
  input  osd_pkg::rgb_t                       i_color,
  output osd_pkg::video_t                     o_video
);

  osd_pkg::video_t vid_d1;
  osd_pkg::video_t vid_d2;                // lines up with the region hits
  logic            any_hit;

  assign any_hit = |i_hits;               // overlapping windows just OR

  always_ff @(posedge pclk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      vid_d1  <= '0;
      vid_d2  <= '0;
      o_video <= '0;
    end else begin
      vid_d1 <= i_video;
      vid_d2 <= vid_d1;

      o_video.hs <= vid_d2.hs;
      o_video.vs <= vid_d2.vs;
      o_video.de <= vid_d2.de;

      if (any_hit) begin
        o_video.data <= i_color;          // lit font pixel
      end else begin
        o_video.data <= vid_d2.data;
      end
    end
  end

endmodule

`default_nettype wire

/* osd_overlay_top.sv */
`timescale 1ns/1ps
`default_nettype none

module osd_overlay_top (
  input  logic               pclk,
  input  logic               i_arst_n,
  input  logic               i_hs,
  input  logic               i_vs,
  input  logic               i_de,
  input  osd_pkg::rgb_t      i_data,
  input  logic               i_psel,
  input  logic               i_penable,
  input  logic               i_pwrite,
  input  osd_pkg::apb_addr_t i_paddr,
  input  osd_pkg::apb_data_t i_pwdata,
  output osd_pkg::apb_data_t o_prdata,
  output logic               o_pready,
  output logic               o_pslverr,
  output logic               o_hs,
  output logic               o_vs,
  output logic               o_de,
  output osd_pkg::rgb_t      o_data
);

  osd_pkg::video_t                                     video_in;
  osd_pkg::video_t                                     video_out;
  osd_pkg::video_xy_t                                  video_xy;
  osd_pkg::rgb_t                                       font_color;
  osd_pkg::region_cfg_t [osd_pkg::osd_num_regions-1:0] region_cfg;
  osd_pkg::glyph_wr_t                                  glyph_wr;
  logic [osd_pkg::osd_num_regions-1:0]                 hits;

  assign video_in = '{hs: i_hs, vs: i_vs, de: i_de, data: i_data};

  assign o_hs   = video_out.hs;
  assign o_vs   = video_out.vs;
  assign o_de   = video_out.de;
  assign o_data = video_out.data;

  timing_gen_xy timing_gen_xy_inst (
    .pclk      (pclk),
    .i_arst_n  (i_arst_n),
    .i_video   (video_in),
    .o_video_xy(video_xy)
  );

  osd_apb_regs osd_apb_regs_inst (
    .pclk        (pclk),
    .i_arst_n    (i_arst_n),
    .i_psel      (i_psel),
    .i_penable   (i_penable),
    .i_pwrite    (i_pwrite),
    .i_paddr     (i_paddr),
    .i_pwdata    (i_pwdata),
    .o_prdata    (o_prdata),
    .o_pready    (o_pready),
    .o_pslverr   (o_pslverr),
    .o_color     (font_color),
    .o_region_cfg(region_cfg),
    .o_glyph_wr  (glyph_wr)
  );

  for (genvar gi = 0; gi < osd_pkg::osd_num_regions; gi++) begin : g_region
    osd_region osd_region_inst (
      .pclk       (pclk),
      .i_arst_n   (i_arst_n),
      .i_video_xy (video_xy),
      .i_cfg      (region_cfg[gi]),
      .i_glyph_wr (glyph_wr),
      .i_region_id(2'(gi)),
      .o_hit      (hits[gi])
    );
  end

  osd_mixer osd_mixer_inst (
    .pclk    (pclk),
    .i_arst_n(i_arst_n),
    .i_video (video_xy.video),
    .i_hits  (hits),
    .i_color (font_color),
    .o_video (video_out)
  );

endmodule

`default_nettype wire

/* osd_overlay_props.sv */
`timescale 1ns/1ps
`default_nettype none

module osd_overlay_props (
  input logic pclk,
  input logic i_arst_n,
  input logic i_de,
  input logic i_psel,
  input logic i_penable,
  input logic o_de,
  input logic o_pready,
  input logic o_pslverr
);

  int fail_count = 0;

  // whole video path is 4 registers deep
  de_latency: assert property (@(posedge pclk) disable iff (!i_arst_n)
    o_de == $past(i_de, 4))
    else begin
      fail_count++;
      $error("o_de is not i_de delayed by 4 cycles");
    end

  pready_high: assert property (@(posedge pclk) disable iff (!i_arst_n) o_pready)
    else begin
      fail_count++;
      $error("o_pready went low");
    end

  // error only in an access phase
  pslverr_in_access: assert property (@(posedge pclk) disable iff (!i_arst_n)
    o_pslverr |-> (i_psel && i_penable))
    else begin
      fail_count++;
      $error("o_pslverr high outside an APB access phase");
    end

  de_low_in_reset: assert property (@(posedge pclk) !i_arst_n |-> !o_de)
    else begin
      fail_count++;
      $error("o_de high while reset is asserted");
    end

endmodule

bind osd_overlay_top osd_overlay_props osd_overlay_props_inst (
  .pclk     (pclk),
  .i_arst_n (i_arst_n),
  .i_de     (i_de),
  .i_psel   (i_psel),
  .i_penable(i_penable),
  .o_de     (o_de),
  .o_pready (o_pready),
  .o_pslverr(o_pslverr)
);

`default_nettype wire

/* tb_osd_overlay.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_osd_overlay;

  localparam int frame_lines = 24;
  localparam int line_pixels = 96;
  localparam int apb_timeout = 16;        // cycles allowed for pready

  logic                 pclk;
  logic                 arst_n;
  logic                 hs;
  logic                 vs;
  logic                 de;
  osd_pkg::rgb_t        pix_data;
  logic                 psel;
  logic                 penable;
  logic                 pwrite;
  osd_pkg::apb_addr_t   paddr;
  osd_pkg::apb_data_t   pwdata;
  osd_pkg::apb_data_t   prdata;
  logic                 pready;
  logic                 pslverr;
  logic                 out_hs;
  logic                 out_vs;
  logic                 out_de;
  osd_pkg::rgb_t        out_data;

  osd_pkg::rgb_t        color_shadow;
  osd_pkg::region_cfg_t cfg_shadow [osd_pkg::osd_num_regions];
  osd_pkg::glyph_byte_t glyph_shadow [osd_pkg::osd_num_regions][osd_pkg::osd_glyph_bytes];
  osd_pkg::video_t      exp_line [$];     // expected outputs still in the DUT pipeline
  int                   ref_x;
  int                   ref_y;
  logic                 prev_de;
  logic [31:0]          lcg_state;
  string                test_name;

  osd_overlay_top osd_overlay_top_inst (
    .pclk     (pclk),
    .i_arst_n (arst_n),
    .i_hs     (hs),
    .i_vs     (vs),
    .i_de     (de),
    .i_data   (pix_data),
    .i_psel   (psel),
    .i_penable(penable),
    .i_pwrite (pwrite),
    .i_paddr  (paddr),
    .i_pwdata (pwdata),
    .o_prdata (prdata),
    .o_pready (pready),
    .o_pslverr(pslverr),
    .o_hs     (out_hs),
    .o_vs     (out_vs),
    .o_de     (out_de),
    .o_data   (out_data)
  );

  initial begin
    pclk = 1'b0;
    forever #50 pclk = ~pclk;             // 100 ns period
  end

  function automatic logic [31:0] next_random();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("Checks failed");
    $fatal(1);
  endtask

  task automatic report_mismatch(input string what, input logic [31:0] expected,
                                 input logic [31:0] actual);
    abort_run($sformatf("Error: %s %s expected %0h actual %0h",
                        test_name, what, expected, actual));
  endtask

  // lit if any enabled window covers the pixel and its bitmap bit is set
  function automatic osd_pkg::rgb_t expected_data(input int x, input int y,
                                                  input osd_pkg::rgb_t pix);
    int                   n;
    int                   dx;
    int                   dy;
    logic [2:0]           bit_idx;
    osd_pkg::glyph_byte_t gbyte;
    logic                 lit;
    lit = 1'b0;
    for (n = 0; n < osd_pkg::osd_num_regions; n++) begin
      dx = x - int'(cfg_shadow[n].org_x);
      dy = y - int'(cfg_shadow[n].org_y);
      if (cfg_shadow[n].en && dx >= 0 && dx < osd_pkg::osd_win_w &&
          dy >= 0 && dy < osd_pkg::osd_win_h) begin
        gbyte   = glyph_shadow[n][dy * (osd_pkg::osd_win_w / 8) + dx / 8];
        bit_idx = 3'(dx % 8);
        if (gbyte[bit_idx]) begin
          lit = 1'b1;
        end
      end
    end
    return lit ? color_shadow : pix;
  endfunction

  task automatic drive_pixel(input logic p_hs, input logic p_vs, input logic p_de,
                             input osd_pkg::rgb_t p_data);
    @(posedge pclk);
    hs       <= p_hs;
    vs       <= p_vs;
    de       <= p_de;
    pix_data <= p_data;
  endtask

  task automatic drive_blank(input logic p_hs, input logic p_vs, input int cycles);
    repeat (cycles) drive_pixel(p_hs, p_vs, 1'b0, '0);
  endtask

  task automatic send_frame();
    int line;
    int px;
    drive_blank(1'b0, 1'b1, 4);           // vs pulse
    drive_blank(1'b0, 1'b0, 8);
    for (line = 0; line < frame_lines; line++) begin
      drive_blank(1'b1, 1'b0, 4);         // hs pulse
      drive_blank(1'b0, 1'b0, 4);
      for (px = 0; px < line_pixels; px++) begin
        drive_pixel(1'b0, 1'b0, 1'b1, 24'(next_random()));
      end
      drive_blank(1'b0, 1'b0, 4);
    end
    drive_blank(1'b0, 1'b0, 8);           // drain the pipeline
  endtask

  task automatic apb_transfer(input logic write, input osd_pkg::apb_addr_t addr,
                              input osd_pkg::apb_data_t wdata,
                              output osd_pkg::apb_data_t rdata, output logic err);
    int waited;
    @(posedge pclk);
    psel    <= 1'b1;
    penable <= 1'b0;
    pwrite  <= write;
    paddr   <= addr;
    pwdata  <= wdata;
    @(posedge pclk);
    penable <= 1'b1;
    waited = 0;
    do begin
      @(posedge pclk);
      waited++;
    end while (!pready && waited < apb_timeout);
    if (!pready) begin
      abort_run($sformatf("APB access to %0h did not complete, pready stayed low", addr));
    end else begin
      rdata = prdata;
      err   = pslverr;
      psel    <= 1'b0;
      penable <= 1'b0;
      pwrite  <= 1'b0;
    end
  endtask

  task automatic write_checked(input osd_pkg::apb_addr_t addr, input osd_pkg::apb_data_t data,
                               input logic exp_err);
    osd_pkg::apb_data_t rdata;
    logic               err;
    apb_transfer(1'b1, addr, data, rdata, err);
    assert (err == exp_err) else report_mismatch("write pslverr", 32'(exp_err), 32'(err));
  endtask

  task automatic read_checked(input osd_pkg::apb_addr_t addr, input osd_pkg::apb_data_t expected,
                              input logic exp_err);
    osd_pkg::apb_data_t rdata;
    logic               err;
    apb_transfer(1'b0, addr, '0, rdata, err);
    assert (err == exp_err) else report_mismatch("read pslverr", 32'(exp_err), 32'(err));
    if (!exp_err) begin
      assert (rdata == expected) else report_mismatch("prdata", expected, rdata);
    end
  endtask

  task automatic write_color(input osd_pkg::rgb_t color);
    write_checked(osd_pkg::reg_color_addr, {8'h00, color}, 1'b0);
    color_shadow = color;
  endtask

  task automatic write_region(input int n, input logic en, input osd_pkg::coord_t x,
                              input osd_pkg::coord_t y);
    write_checked(osd_pkg::reg_region_base + 12'(4 * n), {en, 7'h00, y, x}, 1'b0);
    cfg_shadow[n] = '{en: en, org_x: x, org_y: y};
  endtask

  task automatic check_region(input int n);
    read_checked(osd_pkg::reg_region_base + 12'(4 * n),
                 {cfg_shadow[n].en, 7'h00, cfg_shadow[n].org_y, cfg_shadow[n].org_x}, 1'b0);
  endtask

  task automatic write_glyph(input int n, input int b, input osd_pkg::glyph_byte_t v);
    write_checked(osd_pkg::glyph_base + 12'(128 * n + b), {24'h000000, v}, 1'b0);
    glyph_shadow[n][b] = v;
  endtask

  // reference model sees one pixel per clock and is compared 4 cycles later
  always @(posedge pclk) begin
    osd_pkg::video_t exp_now;
    osd_pkg::video_t exp_old;
    if (!arst_n) begin
      exp_line.delete();
      ref_x   = 0;
      ref_y   = 0;
      prev_de = 1'b0;
    end else begin
      if (osd_overlay_top_inst.osd_overlay_props_inst.fail_count != 0) begin
        abort_run("a bound property assertion failed");
      end
      if (vs) begin
        ref_y = 0;
      end else if (prev_de && !de) begin
        ref_y = ref_y + 1;                // an active line just ended
      end
      exp_now.hs   = hs;
      exp_now.vs   = vs;
      exp_now.de   = de;
      exp_now.data = de ? expected_data(ref_x, ref_y, pix_data) : pix_data;
      ref_x   = de ? ref_x + 1 : 0;
      prev_de = de;
      exp_line.push_back(exp_now);
      if (exp_line.size() > 4) begin
        exp_old = exp_line.pop_front();
        assert (out_data == exp_old.data)
          else report_mismatch("o_data", 32'(exp_old.data), 32'(out_data));
        assert (out_de == exp_old.de) else report_mismatch("o_de", 32'(exp_old.de), 32'(out_de));
        assert (out_hs == exp_old.hs) else report_mismatch("o_hs", 32'(exp_old.hs), 32'(out_hs));
        assert (out_vs == exp_old.vs) else report_mismatch("o_vs", 32'(exp_old.vs), 32'(out_vs));
      end
    end
  end

  initial begin
    int                 n;
    int                 b;
    osd_pkg::apb_data_t rnd;
    arst_n   <= 1'b0;
    hs       <= 1'b0;
    vs       <= 1'b0;
    de       <= 1'b0;
    pix_data <= '0;
    psel     <= 1'b0;
    penable  <= 1'b0;
    pwrite   <= 1'b0;
    paddr    <= '0;
    pwdata   <= '0;
    lcg_state = 32'h22efbd0c;
    test_name = "reset";
    color_shadow = osd_pkg::osd_default_color;
    for (n = 0; n < osd_pkg::osd_num_regions; n++) begin
      cfg_shadow[n] = '0;
    end
    repeat (4) @(posedge pclk);
    arst_n <= 1'b1;
    drive_blank(1'b0, 1'b0, 4);

    test_name = "passthrough";
    send_frame();

    test_name = "register access";
    read_checked(osd_pkg::reg_color_addr, 32'(osd_pkg::osd_default_color), 1'b0);
    for (n = 0; n < osd_pkg::osd_num_regions; n++) begin
      rnd = next_random();
      write_region(n, rnd[31], rnd[11:0], rnd[23:12]);
    end
    for (n = 0; n < osd_pkg::osd_num_regions; n++) begin
      check_region(n);
    end
    write_glyph(0, 0, 8'hff);             // nonzero bytes behind the reads
    write_glyph(2, osd_pkg::osd_glyph_bytes - 1, 8'hff);
    read_checked(osd_pkg::glyph_base, '0, 1'b0);
    read_checked(osd_pkg::glyph_base + 12'h17f, '0, 1'b0);

    test_name = "glyph overlay";
    for (n = 0; n < osd_pkg::osd_num_regions; n++) begin
      for (b = 0; b < osd_pkg::osd_glyph_bytes; b++) begin
        write_glyph(n, b, 8'(next_random()));
      end
    end
    write_region(0, 1'b1, 12'd10, 12'd3);
    write_region(1, 1'b0, 12'd40, 12'd4);
    write_region(2, 1'b0, 12'd0, 12'd20);
    send_frame();

    test_name = "colour and three regions";
    write_color(24'(next_random()));
    write_region(1, 1'b1, 12'd40, 12'd4);   // overlaps region 0
    write_region(2, 1'b1, 12'd0, 12'd20);
    read_checked(osd_pkg::reg_color_addr, {8'h00, color_shadow}, 1'b0);
    send_frame();

    test_name = "bus error";
    write_checked(12'h008, next_random(), 1'b1);
    write_checked(12'h01c, next_random(), 1'b1);   // one past the last region
    read_checked(12'h300, '0, 1'b1);
    read_checked(osd_pkg::reg_color_addr, {8'h00, color_shadow}, 1'b0);
    for (n = 0; n < osd_pkg::osd_num_regions; n++) begin
      check_region(n);
    end

    test_name = "disable";
    write_region(0, 1'b0, 12'd10, 12'd3);
    send_frame();

    if (osd_overlay_top_inst.osd_overlay_props_inst.fail_count == 0) begin
      $display("All checks passed");
      $finish;
    end else begin
      abort_run("a bound property assertion failed during the run");
    end
  end

endmodule

`default_nettype wire

/* files.f */
osd_pkg.sv
timing_gen_xy.sv
osd_apb_regs.sv
osd_region.sv
osd_mixer.sv
osd_overlay_top.sv
osd_overlay_props.sv
tb_osd_overlay.sv

/* run.sh */
#!/usr/bin/env bash
# compile with Verilator, run, and decide on the pass line in the output
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module tb_osd_overlay -f files.f \
  || { echo "build failed"; exit 1; }

sim_out="$(./obj_dir/Vtb_osd_overlay 2>&1)"
echo "$sim_out"

echo "$sim_out" | grep -qx "All checks passed" && echo "PASS" || { echo "FAIL"; exit 1; }
